// ==== rtl/rv_decode_cfg.svh ====
`ifndef RV_DECODE_CFG_SVH
`define RV_DECODE_CFG_SVH

// ==================================================
// Decode stage build options
// ==================================================

// Register and instruction width, decoder written for 32
`define RV_XLEN 32

// A extension opcode, 0 makes it illegal
`define RV_ATOMIC_EN 1

`endif

// ==== rtl/rv_decode_pkg.sv ====
`include "rv_decode_cfg.svh"

package rv_decode_pkg;

    // ==================================================
    // Instruction field types
    // ==================================================
    typedef logic [31:0]          instr_t;
    typedef logic [`RV_XLEN-1:0]  word_t;      // Immediates and trap value
    typedef logic [6:0]           opcode_t;
    typedef logic [2:0]           funct3_t;
    typedef logic [6:0]           funct7_t;
    typedef logic [4:0]           reg_idx_t;
    typedef logic [3:0]           op_class_t;

    // ==================================================
    // RV32 major opcodes
    // ==================================================
    localparam opcode_t LW_OPCODE        = 7'b0000011;
    localparam opcode_t SW_OPCODE        = 7'b0100011;
    localparam opcode_t JAL_OPCODE       = 7'b1101111;
    localparam opcode_t CSR_OPCODE       = 7'b1110011;   // Also ecall/ebreak
    localparam opcode_t JALR_OPCODE      = 7'b1100111;
    localparam opcode_t AUIPC_OPCODE     = 7'b0010111;
    localparam opcode_t BRANCH_OPCODE    = 7'b1100011;
    localparam opcode_t IMMEDIATE_OPCODE = 7'b0010011;
    localparam opcode_t RTYPE_OPCODE     = 7'b0110011;
    localparam opcode_t ATOMIC_OPCODE    = 7'b0101111;
    localparam opcode_t LUI_OPCODE       = 7'b0110111;

    // ==================================================
    // Operation classes
    // ==================================================
    localparam op_class_t CLS_NONE    = 4'd0;    // Unknown encoding
    localparam op_class_t CLS_LOAD    = 4'd1;
    localparam op_class_t CLS_STORE   = 4'd2;
    localparam op_class_t CLS_JUMP    = 4'd3;    // JAL and JALR
    localparam op_class_t CLS_BRANCH  = 4'd4;
    localparam op_class_t CLS_ALU_IMM = 4'd5;
    localparam op_class_t CLS_ALU_REG = 4'd6;
    localparam op_class_t CLS_UPPER   = 4'd7;    // LUI and AUIPC
    localparam op_class_t CLS_SYSTEM  = 4'd8;
    localparam op_class_t CLS_ATOMIC  = 4'd9;

endpackage

// ==== rtl/invalid_ir_check.sv ====
`timescale 1ns/1ps
`include "rv_decode_cfg.svh"

module invalid_ir_check (
    input  rv_decode_pkg::instr_t instr_i,
    output logic                  invalid_instruction_o
);

    import rv_decode_pkg::*;

    opcode_t opcode;
    funct3_t funct3;

    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];

    // ==================================================
    // Legality per opcode and funct3
    // ==================================================
    always_comb begin : ir_invalid_checker
        unique case (opcode)
            LW_OPCODE: begin
                unique case (funct3)
                    3'b000, 3'b001, 3'b010, 3'b100, 3'b101: invalid_instruction_o = 1'b0;
                    default: invalid_instruction_o = 1'b1;   // No LD/LWU on RV32
                endcase
            end
            SW_OPCODE: begin
                unique case (funct3)
                    3'b000, 3'b001, 3'b010: invalid_instruction_o = 1'b0;
                    default: invalid_instruction_o = 1'b1;
                endcase
            end
            JAL_OPCODE: begin
                invalid_instruction_o = 1'b0;
            end
            CSR_OPCODE: begin
                unique case (funct3)
                    3'b011, 3'b111: invalid_instruction_o = 1'b1;   // Reserved
                    default: invalid_instruction_o = 1'b0;
                endcase
            end
            JALR_OPCODE: begin
                invalid_instruction_o = (funct3 == 3'b000) ? 1'b0 : 1'b1;
            end
            AUIPC_OPCODE: begin
                invalid_instruction_o = 1'b0;
            end
            BRANCH_OPCODE: begin
                unique case (funct3)
                    3'b010, 3'b011: invalid_instruction_o = 1'b1;   // Holes in the table
                    default: invalid_instruction_o = 1'b0;
                endcase
            end
            IMMEDIATE_OPCODE: begin
                invalid_instruction_o = 1'b0;
            end
            RTYPE_OPCODE: begin
                invalid_instruction_o = 1'b0;
            end
            ATOMIC_OPCODE: begin
                invalid_instruction_o = (`RV_ATOMIC_EN != 0) ? 1'b0 : 1'b1;
            end
            LUI_OPCODE: begin
                invalid_instruction_o = 1'b0;
            end
            default: begin
                invalid_instruction_o = 1'b1;
            end
        endcase
    end

endmodule

// ==== rtl/instr_decoder.sv ====
`timescale 1ns/1ps
`include "rv_decode_cfg.svh"

module instr_decoder (
    input  rv_decode_pkg::instr_t    instr_i,
    output rv_decode_pkg::reg_idx_t  rd_o,
    output rv_decode_pkg::reg_idx_t  rs1_o,
    output rv_decode_pkg::reg_idx_t  rs2_o,
    output rv_decode_pkg::funct3_t   funct3_o,
    output rv_decode_pkg::funct7_t   funct7_o,
    output rv_decode_pkg::word_t     imm_o,
    output rv_decode_pkg::op_class_t op_class_o,
    output logic                     rd_we_o
);

    import rv_decode_pkg::*;

    opcode_t opcode;
    word_t   imm_i_type;
    word_t   imm_s_type;
    word_t   imm_b_type;
    word_t   imm_u_type;
    word_t   imm_j_type;

    // ==================================================
    // Field split
    // ==================================================
    assign opcode   = instr_i[6:0];
    assign rd_o     = instr_i[11:7];
    assign funct3_o = instr_i[14:12];
    assign rs1_o    = instr_i[19:15];
    assign rs2_o    = instr_i[24:20];
    assign funct7_o = instr_i[31:25];

    // ==================================================
    // Immediate formats, all sign-extended from bit 31
    // ==================================================
    assign imm_i_type = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_s_type = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    assign imm_b_type = {{19{instr_i[31]}}, instr_i[31], instr_i[7],
                         instr_i[30:25], instr_i[11:8], 1'b0};
    assign imm_u_type = {instr_i[31:12], 12'b0};
    assign imm_j_type = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12],
                         instr_i[20], instr_i[30:21], 1'b0};

    always_comb begin : imm_select
        unique case (opcode)
            LW_OPCODE,
            JALR_OPCODE,
            IMMEDIATE_OPCODE,
            CSR_OPCODE: begin
                imm_o = imm_i_type;   // CSR address sits here
            end
            SW_OPCODE: begin
                imm_o = imm_s_type;
            end
            BRANCH_OPCODE: begin
                imm_o = imm_b_type;
            end
            LUI_OPCODE,
            AUIPC_OPCODE: begin
                imm_o = imm_u_type;
            end
            JAL_OPCODE: begin
                imm_o = imm_j_type;
            end
            default: begin
                imm_o = '0;           // R-type, atomic, unknown
            end
        endcase
    end

    // ==================================================
    // Operation class
    // ==================================================
    always_comb begin : class_map
        unique case (opcode)
            LW_OPCODE:        op_class_o = CLS_LOAD;
            SW_OPCODE:        op_class_o = CLS_STORE;
            JAL_OPCODE:       op_class_o = CLS_JUMP;
            JALR_OPCODE:      op_class_o = CLS_JUMP;
            BRANCH_OPCODE:    op_class_o = CLS_BRANCH;
            IMMEDIATE_OPCODE: op_class_o = CLS_ALU_IMM;
            RTYPE_OPCODE:     op_class_o = CLS_ALU_REG;
            LUI_OPCODE:       op_class_o = CLS_UPPER;
            AUIPC_OPCODE:     op_class_o = CLS_UPPER;
            CSR_OPCODE:       op_class_o = CLS_SYSTEM;
            ATOMIC_OPCODE: begin
                op_class_o = (`RV_ATOMIC_EN != 0) ? CLS_ATOMIC : CLS_NONE;
            end
            default:          op_class_o = CLS_NONE;
        endcase
    end

    // Writes to x0 are dropped here already
    assign rd_we_o = (op_class_o != CLS_STORE) &&
                     (op_class_o != CLS_BRANCH) &&
                     (rd_o != 5'd0);

endmodule

// ==== rtl/decode_stage.sv ====
`timescale 1ns/1ps
`include "rv_decode_cfg.svh"

module decode_stage (
    input  logic                     clk,
    input  logic                     arst_n_i,
    input  logic                     instr_valid_i,
    input  rv_decode_pkg::instr_t    instr_i,
    output logic                     dec_valid_o,
    output logic                     illegal_o,
    output rv_decode_pkg::word_t     mtval_o,
    output rv_decode_pkg::op_class_t op_class_o,
    output rv_decode_pkg::reg_idx_t  rd_o,
    output rv_decode_pkg::reg_idx_t  rs1_o,
    output rv_decode_pkg::reg_idx_t  rs2_o,
    output rv_decode_pkg::funct3_t   funct3_o,
    output rv_decode_pkg::word_t     imm_o,
    output logic                     rd_we_o
);

    import rv_decode_pkg::*;

    instr_t    ir_q;
    logic      ir_valid_q;
    logic      chk_illegal;
    reg_idx_t  dec_rd;
    reg_idx_t  dec_rs1;
    reg_idx_t  dec_rs2;
    funct3_t   dec_funct3;
    word_t     dec_imm;
    op_class_t dec_class;
    logic      dec_rd_we;

    // ==================================================
    // Stage 1, instruction register
    // ==================================================
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ir_valid_q <= 1'b0;
            ir_q       <= '0;
        end else begin
            ir_valid_q <= instr_valid_i;
            if (instr_valid_i) begin
                ir_q <= instr_i;
            end
        end
    end

    invalid_ir_check i_invalid_ir_check (
        .instr_i               (ir_q),
        .invalid_instruction_o (chk_illegal)
    );

    instr_decoder i_instr_decoder (
        .instr_i    (ir_q),
        .rd_o       (dec_rd),
        .rs1_o      (dec_rs1),
        .rs2_o      (dec_rs2),
        .funct3_o   (dec_funct3),
        .funct7_o   (),              // Not needed past decode
        .imm_o      (dec_imm),
        .op_class_o (dec_class),
        .rd_we_o    (dec_rd_we)
    );

    // ==================================================
    // Stage 2, decoded output register
    // ==================================================
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            dec_valid_o <= 1'b0;
            illegal_o   <= 1'b0;
            mtval_o     <= '0;
            op_class_o  <= CLS_NONE;
            rd_o        <= '0;
            rs1_o       <= '0;
            rs2_o       <= '0;
            funct3_o    <= '0;
            imm_o       <= '0;
            rd_we_o     <= 1'b0;
        end else begin
            dec_valid_o <= ir_valid_q;
            illegal_o   <= ir_valid_q & chk_illegal;   // Never high without valid
            if (ir_valid_q) begin
                mtval_o    <= chk_illegal ? ir_q[`RV_XLEN-1:0] : '0;
                op_class_o <= dec_class;
                rd_o       <= dec_rd;
                rs1_o      <= dec_rs1;
                rs2_o      <= dec_rs2;
                funct3_o   <= dec_funct3;
                imm_o      <= dec_imm;
                rd_we_o    <= dec_rd_we & ~chk_illegal;   // Faulting instr never writes
            end
        end
    end

endmodule

// ==== testbench/tb_decode_stage.sv ====
`timescale 1ns/1ps
`include "rv_decode_cfg.svh"

module tb_decode_stage;

    import rv_decode_pkg::*;

    localparam int MAX_TESTS     = 96;
    localparam int PULSE_TIMEOUT = 20;   // Cycles, longest trace gap is 3

    logic      clk;
    logic      arst_n_i;
    logic      instr_valid_i;
    instr_t    instr_i;
    logic      dec_valid_o;
    logic      illegal_o;
    word_t     mtval_o;
    op_class_t op_class_o;
    reg_idx_t  rd_o;
    reg_idx_t  rs1_o;
    reg_idx_t  rs2_o;
    funct3_t   funct3_o;
    word_t     imm_o;
    logic      rd_we_o;

    string       tr_name  [MAX_TESTS];
    logic [31:0] tr_instr [MAX_TESTS];
    logic [31:0] tr_ill   [MAX_TESTS];
    logic [31:0] tr_cls   [MAX_TESTS];
    logic [31:0] tr_rd    [MAX_TESTS];
    logic [31:0] tr_we    [MAX_TESTS];
    logic [31:0] tr_imm   [MAX_TESTS];
    int          tr_gap   [MAX_TESTS];
    int          n_tests    = 0;
    int          idx_q  [$];              // Trace index per instruction in flight
    int unsigned edge_q [$];              // Its sampling edge
    int unsigned cyc        = 0;
    integer      seed;
    string       cur_name;
    int          test_errs  = 0;
    int          pass_count = 0;
    int          fail_count = 0;
    int          other_errs = 0;

    decode_stage i_dut (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .dec_valid_o   (dec_valid_o),
        .illegal_o     (illegal_o),
        .mtval_o       (mtval_o),
        .op_class_o    (op_class_o),
        .rd_o          (rd_o),
        .rs1_o         (rs1_o),
        .rs2_o         (rs2_o),
        .funct3_o      (funct3_o),
        .imm_o         (imm_o),
        .rd_we_o       (rd_we_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;                   // Rising edges so far
    end

    // ==================================================
    // Trace loading
    // ==================================================
    task automatic load_trace();
        int          fd;
        int          cnt;
        string       line;
        string       name;
        logic [31:0] w;
        logic [31:0] ill;
        logic [31:0] cls;
        logic [31:0] rd;
        logic [31:0] we;
        logic [31:0] imm;
        int          gap;
        fd = $fopen("testbench/decode_trace.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the trace file testbench/decode_trace.txt");
            other_errs++;
            return;
        end
        while (n_tests < MAX_TESTS) begin
            if ($fgets(line, fd) == 0) break;
            if (line.len() == 0 || line.getc(0) == "#") continue;
            cnt = $sscanf(line, "%s %h %d %d %d %d %h %d", name, w, ill, cls, rd, we, imm, gap);
            if (cnt != 8) continue;       // Blank or short line
            tr_name[n_tests]  = name;
            tr_instr[n_tests] = w;
            tr_ill[n_tests]   = ill;
            tr_cls[n_tests]   = cls;
            tr_rd[n_tests]    = rd;
            tr_we[n_tests]    = we;
            tr_imm[n_tests]   = imm;
            tr_gap[n_tests]   = gap;
            n_tests++;
        end
        $fclose(fd);
        if (n_tests == 0) begin
            $display("The trace file holds no test lines");
            other_errs++;
        end
    endtask

    // ==================================================
    // Stimulus
    // ==================================================
    task automatic drive_trace();
        int gap;
        for (int i = 0; i < n_tests; i++) begin
            @(negedge clk);
            instr_valid_i = 1'b1;
            instr_i       = tr_instr[i];
            idx_q.push_back(i);
            edge_q.push_back(cyc + 1);
            gap = tr_gap[i];
            if (gap < 0) gap = $unsigned($random(seed)) % 4;
            for (int j = 0; j < gap; j++) begin
                @(negedge clk);
                instr_valid_i = 1'b0;
                instr_i       = $random(seed);   // Junk, must not be captured
            end
        end
        @(negedge clk);
        instr_valid_i = 1'b0;
        instr_i       = '0;
    endtask

    // ==================================================
    // Checking
    // ==================================================
    task automatic check_value(input string sig, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("ERROR: %s %s = 0x%08h, expected 0x%08h", cur_name, sig, got, exp);
            test_errs++;
        end
    endtask

    task automatic check_idle();
        assert (illegal_o === 1'b0) else begin
            $display("ERROR: illegal_o = 0x%h without dec_valid_o, expected 0x0", illegal_o);
            other_errs++;
        end
    endtask

    task automatic check_pulse(input int idx, input int unsigned sample_edge);
        logic [31:0] w;
        logic [31:0] exp_ill;
        logic [31:0] exp_cls;
        logic [31:0] exp_we;
        w         = tr_instr[idx];
        exp_ill   = tr_ill[idx];
        exp_cls   = tr_cls[idx];
        exp_we    = tr_we[idx];
        cur_name  = tr_name[idx];
        test_errs = 0;
        if (w[6:0] == 7'h2f && `RV_ATOMIC_EN == 0) begin   // Atomic opcode disabled
            exp_ill = 32'd1;
            exp_cls = 32'd0;
            exp_we  = 32'd0;
        end
        assert (cyc == sample_edge + 1) else begin
            $display("%s: dec_valid_o after %0d clock edges, expected 2",
                     cur_name, cyc - sample_edge + 1);
            test_errs++;
        end
        check_value("illegal_o", {31'd0, illegal_o}, exp_ill);
        check_value("mtval_o", mtval_o, exp_ill[0] ? w : 32'h0);
        check_value("op_class_o", {28'd0, op_class_o}, exp_cls);
        check_value("rd_o", {27'd0, rd_o}, tr_rd[idx]);
        check_value("rs1_o", {27'd0, rs1_o}, {27'd0, w[19:15]});
        check_value("rs2_o", {27'd0, rs2_o}, {27'd0, w[24:20]});
        check_value("funct3_o", {29'd0, funct3_o}, {29'd0, w[14:12]});
        check_value("imm_o", imm_o, tr_imm[idx]);
        check_value("rd_we_o", {31'd0, rd_we_o}, exp_we);
        if (test_errs == 0) begin
            pass_count++;
            $display("PASS %s", cur_name);
        end else begin
            fail_count++;
            $display("FAIL %s, %0d mismatches", cur_name, test_errs);
        end
    endtask

    task automatic watch_outputs();
        int waited;
        for (int k = 0; k < n_tests; k++) begin
            waited = 0;
            @(negedge clk);
            while (dec_valid_o !== 1'b1 && waited < PULSE_TIMEOUT) begin
                check_idle();
                @(negedge clk);
                waited++;
            end
            if (dec_valid_o !== 1'b1) begin
                $display("Timeout: no dec_valid_o pulse within %0d cycles for instruction %0d",
                         PULSE_TIMEOUT, k);
                other_errs++;
                return;
            end
            if (idx_q.size() == 0) begin
                $display("dec_valid_o pulsed with no instruction outstanding");
                other_errs++;
                return;
            end
            check_pulse(idx_q.pop_front(), edge_q.pop_front());
        end
        for (int k = 0; k < 6; k++) begin     // No extra pulses at the end
            @(negedge clk);
            assert (dec_valid_o === 1'b0) else begin
                $display("dec_valid_o pulsed again after the last instruction");
                other_errs++;
            end
        end
    endtask

    initial begin
        seed          = 93763;
        arst_n_i      = 1'b0;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        load_trace();
        repeat (3) @(negedge clk);
        arst_n_i = 1'b1;
        if (n_tests > 0) begin
            fork
                drive_trace();
                watch_outputs();
            join
        end
        $display("Tests: %0d in trace, %0d passed, %0d failed, %0d other errors",
                 n_tests, pass_count, fail_count, other_errs);
        if (n_tests > 0 && pass_count == n_tests && fail_count == 0 && other_errs == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== testbench/decode_trace.txt ====
# name instr(hex) illegal class(0..9) rd we imm(hex) gap
# gap is idle cycles before the next line, -1 picks a random gap of 0 to 3
addi_pos     00500093 0 5 1  1 00000005 0
addi_neg     fff08113 0 5 2  1 ffffffff 0
nop_x0       00000013 0 5 0  0 00000000 0
add_reg      002081b3 0 6 3  1 00000000 0
sub_reg      407302b3 0 6 5  1 00000000 2
lui_pos      12345537 0 7 10 1 12345000 1
lui_neg      fffff5b7 0 7 11 1 fffff000 -1
auipc_msb    80000617 0 7 12 1 80000000 -1
jal_fwd      008000ef 0 3 1  1 00000008 0
jal_back_x0  ffdff06f 0 3 0  0 fffffffc 0
jal_bit11    001002ef 0 3 5  1 00000800 3
jalr_zero    000280e7 0 3 1  1 00000000 -1
jalr_neg     ff0280e7 0 3 1  1 fffffff0 -1
jalr_f3_1    000290e7 1 3 1  0 00000000 0
jalr_f3_2    0002a0e7 1 3 1  0 00000000 0
jalr_f3_3    0002b0e7 1 3 1  0 00000000 0
jalr_f3_4    0002c0e7 1 3 1  0 00000000 0
jalr_f3_5    0002d0e7 1 3 1  0 00000000 0
jalr_f3_6    0002e0e7 1 3 1  0 00000000 0
jalr_f3_7    0002f0e7 1 3 1  0 00000000 2
lb_neg       fff10303 0 1 6  1 ffffffff -1
lh_pos       00211383 0 1 7  1 00000002 -1
lw_pos       00c12203 0 1 4  1 0000000c 0
lbu_zero     00014403 0 1 8  1 00000000 0
lhu_pos      00415483 0 1 9  1 00000004 1
load_f3_3    00013203 1 1 4  0 00000000 0
load_f3_6    00016203 1 1 4  0 00000000 0
load_f3_7    ff817203 1 1 4  0 fffffff8 -1
sb_neg       fe310fa3 0 2 31 0 ffffffff -1
sh_pos       7e311023 0 2 0  0 000007e0 -1
sw_pos       00312423 0 2 8  0 00000008 0
store_f3_3   00313023 1 2 0  0 00000000 0
store_f3_4   00314023 1 2 0  0 00000000 0
store_f3_5   fe315fa3 1 2 31 0 ffffffff 0
store_f3_6   00316023 1 2 0  0 00000000 0
store_f3_7   00317023 1 2 0  0 00000000 1
beq_fwd      00208863 0 4 16 0 00000010 -1
bne_back     fe209ce3 0 4 25 0 fffffff8 -1
blt_bit11    0020c0e3 0 4 1  0 00000800 0
bge_pos      0020d263 0 4 4  0 00000004 0
bltu_pos     0020e263 0 4 4  0 00000004 0
bgeu_pos     0020f263 0 4 4  0 00000004 1
branch_f3_2  0020a063 1 4 0  0 00000000 0
branch_f3_3  0020b863 1 4 16 0 00000010 -1
ecall        00000073 0 8 0  0 00000000 -1
csrrw        300092f3 0 8 5  1 00000300 0
csrrs_neg    c0002373 0 8 6  1 fffffc00 0
csrrwi       300052f3 0 8 5  1 00000300 0
csrrsi       300062f3 0 8 5  1 00000300 0
csr_f3_3     300032f3 1 8 5  0 00000300 0
csr_f3_7     300072f3 1 8 5  0 00000300 2
amoadd_w     0020a2af 0 9 5  1 00000000 0
lr_w         1000a32f 0 9 6  1 00000000 -1
opc_zero     00000000 1 0 0  0 00000000 0
opc_all_ones ffffffff 1 0 31 0 00000000 0
opc_custom0  0000050b 1 0 10 0 00000000 0
opc_flw      00012087 1 0 1  0 00000000 3

// ==== tb.f ====
+incdir+rtl
rtl/rv_decode_pkg.sv
rtl/invalid_ir_check.sv
rtl/instr_decoder.sv
rtl/decode_stage.sv
testbench/tb_decode_stage.sv

// ==== Makefile ====
SIM  := obj_dir/Vtb_decode_stage
SRCS := $(wildcard rtl/*.sv rtl/*.svh testbench/*.sv)

.PHONY: all run clean

all: run

# Rebuilt only when the file list or a source changes
$(SIM): tb.f $(SRCS)
	verilator --binary --assert --timescale 1ns/1ps --top-module tb_decode_stage \
		-Mdir obj_dir -o Vtb_decode_stage -f tb.f

run: $(SIM) testbench/decode_trace.txt
	./$(SIM) > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "Test failures found" sim.log; then echo "Simulation failed"; exit 1; fi
	@grep -q "All tests passed!" sim.log || (echo "Simulation gave no result"; exit 1)

clean:
	rm -rf obj_dir sim.log
